/* ppu_defs.svh */
/*
 * Output post-processing parameters
 * Colour width, RGB range-limit constants and the field
 * widths of the configuration word
 */

`ifndef PPU_DEFS_SVH
`define PPU_DEFS_SVH

// ============================================================
// Video data
// ============================================================

// Bits per colour channel
`define COLOR_W      8

// Limited range: out = c * 220/256 + 16, rounded
`define LIMIT_COEFF  8'd220
`define LIMIT_OFFSET 8'd16

// ============================================================
// Scanline configuration
// ============================================================

// Raw strength code and relative position widths
`define SL_STR_W     4
`define SL_POS_W     8

`endif

/* ppu_pkg.sv */
/*
 * Output post-processing types
 * Pixel bus, raw configuration word and the per-direction
 * scanline settings shared by the VCLK_Tx pipeline
 */

`include "ppu_defs.svh"

package ppu_pkg;

  // Scanline thickness, thin covers the last quarter of a source pixel
  typedef enum logic [1:0] {
    sl_thin   = 2'd0,
    sl_normal = 2'd1,
    sl_thick  = 2'd2,
    sl_full   = 2'd3
  } sl_thickness_e;

  // One scaled pixel with its syncs and position inside the source pixel
  typedef struct packed {
    logic                 vsync;
    logic                 hsync;
    logic                 de;
    logic [`COLOR_W-1:0]  red;
    logic [`COLOR_W-1:0]  green;
    logic [`COLOR_W-1:0]  blue;
    logic [`SL_POS_W-1:0] vpos_rel;
    logic [`SL_POS_W-1:0] hpos_rel;
  } pixel_t;

  // Settings for one scanline direction, strength already expanded
  typedef struct packed {
    logic                en;
    sl_thickness_e       thickness;
    logic [`COLOR_W-1:0] strength;
  } sl_dir_cfg_t;

  // Raw configuration word as delivered by the controller
  typedef struct packed {
    logic                 limited_rgb;
    logic                 h2v_linked;
    logic                 hsl_en;
    sl_thickness_e        hsl_thickness;
    logic [`SL_STR_W-1:0] hsl_str_code;
    logic                 vsl_en;
    sl_thickness_e        vsl_thickness;
    logic [`SL_STR_W-1:0] vsl_str_code;
  } ppu_cfg_word_t;

endpackage

/* ppu_cfg_regs.sv */
/*
 * Configuration register block
 * Turns the raw configuration word into the vertical and
 * horizontal scanline settings and the range-limit enable.
 * One register stage, beside the video pipeline it steers.
 */

`timescale 1ns/1ps

`include "ppu_defs.svh"

module ppu_cfg_regs
  import ppu_pkg::*;
(
  input  logic          VCLK_Tx,
  input  logic          nVRST_Tx,
  input  ppu_cfg_word_t cfg_i,
  output sl_dir_cfg_t   vsl_cfg_o,
  output sl_dir_cfg_t   hsl_cfg_o,
  output logic          limited_rgb_o
);

  // Code n gives 16*(n+1)-1, i.e. the code with all low bits set
  function automatic logic [`COLOR_W-1:0] expand_str(input logic [`SL_STR_W-1:0] code);
    return {code, {(`COLOR_W-`SL_STR_W){1'b1}}};
  endfunction

  sl_dir_cfg_t hsl_next;
  sl_dir_cfg_t vsl_own;
  sl_dir_cfg_t vsl_next;

  assign hsl_next.en        = cfg_i.hsl_en;
  assign hsl_next.thickness = cfg_i.hsl_thickness;
  assign hsl_next.strength  = expand_str(cfg_i.hsl_str_code);

  assign vsl_own.en        = cfg_i.vsl_en;
  assign vsl_own.thickness = cfg_i.vsl_thickness;
  assign vsl_own.strength  = expand_str(cfg_i.vsl_str_code);

  // Linked mode: vertical stage mirrors the whole horizontal setting
  assign vsl_next = cfg_i.h2v_linked ? hsl_next : vsl_own;

  // ============================================================
  // Settings registers
  // ============================================================

  always_ff @(posedge VCLK_Tx or negedge nVRST_Tx) begin
    if (!nVRST_Tx) begin
      hsl_cfg_o     <= '0;
      vsl_cfg_o     <= '0;
      limited_rgb_o <= 1'b0;
    end else begin
      hsl_cfg_o     <= hsl_next;
      vsl_cfg_o     <= vsl_next;
      limited_rgb_o <= cfg_i.limited_rgb;
    end
  end

endmodule

/* scanline_emu.sv */
/*
 * Scanline emulation stage
 * Darkens pixels that fall into the scanline band of one
 * direction. Stage 1 decides the band, stage 2 applies the
 * strength. Syncs and positions travel with the colours.
 */

`timescale 1ns/1ps

`include "ppu_defs.svh"

module scanline_emu
  import ppu_pkg::*;
#(
  parameter bit SL_HORIZONTAL = 1'b0
) (
  input  logic        VCLK_Tx,
  input  logic        nVRST_Tx,
  input  pixel_t      pixel_i,
  input  sl_dir_cfg_t sl_cfg_i,
  output pixel_t      pixel_o
);

  localparam int CW = `COLOR_W;

  // c - floor(c * s / 256)
  function automatic logic [CW-1:0] darken(input logic [CW-1:0] c,
                                           input logic [CW-1:0] s);
    logic [2*CW-1:0] prod;
    prod = (2*CW)'(c) * (2*CW)'(s);
    return c - prod[2*CW-1 -: CW];
  endfunction

  logic [`SL_POS_W-1:0] rel_pos;
  logic [1:0]           pos_top;
  logic [1:0]           band_start;

  pixel_t               pix_s1;
  logic                 band_s1;
  logic [CW-1:0]        str_s1;

  // Horizontal scanlines follow the line position, vertical ones the column
  assign rel_pos    = SL_HORIZONTAL ? pixel_i.vpos_rel : pixel_i.hpos_rel;
  assign pos_top    = rel_pos[`SL_POS_W-1 -: 2];
  assign band_start = 2'd3 - 2'(sl_cfg_i.thickness);

  // ============================================================
  // Stage 1: band decision
  // ============================================================

  always_ff @(posedge VCLK_Tx or negedge nVRST_Tx) begin
    if (!nVRST_Tx) begin
      pix_s1  <= '0;
      band_s1 <= 1'b0;
      str_s1  <= '0;
    end else begin
      pix_s1  <= pixel_i;
      // Blanking is never touched
      band_s1 <= sl_cfg_i.en & pixel_i.de & (pos_top >= band_start);
      // Strength sampled with the pixel so both stages see one setting
      str_s1  <= sl_cfg_i.strength;
    end
  end

  // ============================================================
  // Stage 2: darkening
  // ============================================================

  always_ff @(posedge VCLK_Tx or negedge nVRST_Tx) begin
    if (!nVRST_Tx) begin
      pixel_o <= '0;
    end else begin
      pixel_o <= pix_s1;
      if (band_s1) begin
        pixel_o.red   <= darken(pix_s1.red, str_s1);
        pixel_o.green <= darken(pix_s1.green, str_s1);
        pixel_o.blue  <= darken(pix_s1.blue, str_s1);
      end
    end
  end

endmodule

/* rgb_range_limit.sv */
/*
 * RGB range limiter and output register
 * Scales full-range RGB into 16..235 when limited mode is on,
 * otherwise passes the colours through. Three stages: product,
 * rounding, offset with the final output registers.
 */

`timescale 1ns/1ps

`include "ppu_defs.svh"

module rgb_range_limit
  import ppu_pkg::*;
(
  input  logic                  VCLK_Tx,
  input  logic                  nVRST_Tx,
  input  pixel_t                pixel_i,
  input  logic                  limited_rgb_i,
  output logic                  vsync_o,
  output logic                  hsync_o,
  output logic                  de_o,
  output logic [3*`COLOR_W-1:0] vd_o
);

  localparam int CW = `COLOR_W;

  // Channel 2 is red so the packing matches vd_o
  logic [2:0][CW-1:0]   chan_in;
  logic [2:0][2*CW-1:0] prod;
  logic [2:0][CW:0]     scaled_s1;
  logic [2:0][CW-1:0]   rounded_s2;
  logic [2:0][CW-1:0]   chan_s2;
  pixel_t               pix_s1;
  pixel_t               pix_s2;
  logic                 lim_s1;
  logic                 lim_s2;

  assign chan_in = {pixel_i.red, pixel_i.green, pixel_i.blue};
  assign chan_s2 = {pix_s2.red, pix_s2.green, pix_s2.blue};

  always_comb begin
    for (int i = 0; i < 3; i++) begin
      prod[i] = (2*CW)'(chan_in[i]) * (2*CW)'(`LIMIT_COEFF);
    end
  end

  always_ff @(posedge VCLK_Tx or negedge nVRST_Tx) begin
    if (!nVRST_Tx) begin
      scaled_s1  <= '0;
      rounded_s2 <= '0;
      pix_s1     <= '0;
      pix_s2     <= '0;
      lim_s1     <= 1'b0;
      lim_s2     <= 1'b0;
      vsync_o    <= 1'b0;
      hsync_o    <= 1'b0;
      de_o       <= 1'b0;
      vd_o       <= '0;
    end else begin
      // Mode is taken when the pixel enters
      pix_s1 <= pixel_i;
      lim_s1 <= limited_rgb_i;
      pix_s2 <= pix_s1;
      lim_s2 <= lim_s1;
      for (int i = 0; i < 3; i++) begin
        // floor(c*220/128), one bit more than the result
        scaled_s1[i]  <= prod[i][2*CW-1 -: CW+1];
        // Halve and round half up
        rounded_s2[i] <= scaled_s1[i][CW:1] + CW'(scaled_s1[i][0]);
        vd_o[i*CW +: CW] <= lim_s2 ? rounded_s2[i] + `LIMIT_OFFSET : chan_s2[i];
      end
      vsync_o <= pix_s2.vsync;
      hsync_o <= pix_s2.hsync;
      de_o    <= pix_s2.de;
    end
  end

endmodule

/* ppu_out_top.sv */
/*
 * Output post-processing top level
 * Configuration registers, vertical and horizontal scanline
 * stages and the RGB range limiter on VCLK_Tx. Seven cycles
 * from pixel in to video out.
 */

`timescale 1ns/1ps

`include "ppu_defs.svh"

module ppu_out_top
  import ppu_pkg::*;
(
  input  logic                  VCLK_Tx,
  input  logic                  nVRST_Tx,
  input  ppu_cfg_word_t         cfg_i,
  input  pixel_t                pixel_i,
  output logic                  vsync_o,
  output logic                  hsync_o,
  output logic                  de_o,
  output logic [3*`COLOR_W-1:0] vd_o
);

  sl_dir_cfg_t vsl_cfg;
  sl_dir_cfg_t hsl_cfg;
  logic        limited_rgb;
  pixel_t      v_sl_pix;
  pixel_t      h_sl_pix;

  // ============================================================
  // Configuration
  // ============================================================

  ppu_cfg_regs cfg_regs_u (
    .VCLK_Tx       (VCLK_Tx),
    .nVRST_Tx      (nVRST_Tx),
    .cfg_i         (cfg_i),
    .vsl_cfg_o     (vsl_cfg),
    .hsl_cfg_o     (hsl_cfg),
    .limited_rgb_o (limited_rgb)
  );

  // ============================================================
  // Video pipeline
  // ============================================================

  // Vertical scanlines, banded along the column position
  scanline_emu #(
    .SL_HORIZONTAL (1'b0)
  ) v_sl_u (
    .VCLK_Tx  (VCLK_Tx),
    .nVRST_Tx (nVRST_Tx),
    .pixel_i  (pixel_i),
    .sl_cfg_i (vsl_cfg),
    .pixel_o  (v_sl_pix)
  );

  scanline_emu #(
    .SL_HORIZONTAL (1'b1)
  ) h_sl_u (
    .VCLK_Tx  (VCLK_Tx),
    .nVRST_Tx (nVRST_Tx),
    .pixel_i  (v_sl_pix),
    .sl_cfg_i (hsl_cfg),
    .pixel_o  (h_sl_pix)
  );

  rgb_range_limit range_limit_u (
    .VCLK_Tx       (VCLK_Tx),
    .nVRST_Tx      (nVRST_Tx),
    .pixel_i       (h_sl_pix),
    .limited_rgb_i (limited_rgb),
    .vsync_o       (vsync_o),
    .hsync_o       (hsync_o),
    .de_o          (de_o),
    .vd_o          (vd_o)
  );

endmodule

/* ppu_out_properties.sv */
/*
 * Output post-processing properties
 * Reset state, sync latency and the limited RGB range,
 * checked on the top level through bind
 */

`timescale 1ns/1ps

`include "ppu_defs.svh"

module ppu_out_properties
  import ppu_pkg::*;
(
  input logic                  VCLK_Tx,
  input logic                  nVRST_Tx,
  input ppu_cfg_word_t         cfg_i,
  input pixel_t                pixel_i,
  input logic                  vsync_o,
  input logic                  hsync_o,
  input logic                  de_o,
  input logic [3*`COLOR_W-1:0] vd_o
);

  localparam int LATENCY = 7;

  int unsigned assert_fail_cnt = 0;
  logic [3:0]  lim_cycles;

  function automatic logic in_video_range(input logic [7:0] c);
    return (c >= `LIMIT_OFFSET) && (c <= 8'd235);
  endfunction

  // Consecutive cycles with limited mode requested, saturating
  always_ff @(posedge VCLK_Tx or negedge nVRST_Tx) begin
    if (!nVRST_Tx) begin
      lim_cycles <= '0;
    end else if (!cfg_i.limited_rgb) begin
      lim_cycles <= '0;
    end else if (lim_cycles != 4'd15) begin
      lim_cycles <= lim_cycles + 4'd1;
    end
  end

  // ============================================================
  // Assertions
  // ============================================================

  de_low_in_reset: assert property (@(posedge VCLK_Tx) !nVRST_Tx |-> !de_o)
    else begin
      assert_fail_cnt++;
      $error("de_o high during reset");
    end

  sync_latency: assert property (@(posedge VCLK_Tx) disable iff (!nVRST_Tx)
    (vsync_o == $past(pixel_i.vsync, LATENCY)) &&
    (hsync_o == $past(pixel_i.hsync, LATENCY)) &&
    (de_o == $past(pixel_i.de, LATENCY)))
    else begin
      assert_fail_cnt++;
      $error("Sync outputs do not match the inputs of 7 cycles earlier");
    end

  limited_range: assert property (@(posedge VCLK_Tx) disable iff (!nVRST_Tx)
    (lim_cycles >= 4'd8 && de_o) |->
      (in_video_range(vd_o[23:16]) && in_video_range(vd_o[15:8]) &&
       in_video_range(vd_o[7:0])))
    else begin
      assert_fail_cnt++;
      $error("Colour outside 16..235 in limited mode");
    end

endmodule

bind ppu_out_top ppu_out_properties props_u (
  .VCLK_Tx  (VCLK_Tx),
  .nVRST_Tx (nVRST_Tx),
  .cfg_i    (cfg_i),
  .pixel_i  (pixel_i),
  .vsync_o  (vsync_o),
  .hsync_o  (hsync_o),
  .de_o     (de_o),
  .vd_o     (vd_o)
);

/* tb_ppu_out.sv */
/*
 * Testbench for the output post-processing top level
 * Random pixels and configurations from a fixed seed, checked
 * against a reference model seven cycles after they enter
 */

`timescale 1ns/1ps

`include "ppu_defs.svh"

module tb_ppu_out
  import ppu_pkg::*;
();

  localparam int CLK_PERIOD    = 4;
  localparam int RESET_CYCLES  = 10;
  localparam int IDLE_CYCLES   = 4;
  localparam int LATENCY       = 7;
  localparam int PASS_PIXELS   = 200;
  localparam int SL_BLOCKS     = 8;
  localparam int SL_BLOCK_LEN  = 50;
  localparam int LIMIT_PIXELS  = 300;
  localparam int CHANGE_PIXELS = 400;
  localparam int TOTAL_CYCLES  = RESET_CYCLES + IDLE_CYCLES + PASS_PIXELS +
                                 2 * SL_BLOCKS * SL_BLOCK_LEN + LIMIT_PIXELS + 3 +
                                 CHANGE_PIXELS + 5 * LATENCY;
  localparam int TIMEOUT_NS    = (TOTAL_CYCLES + 100) * CLK_PERIOD;

  // Expected output of one pixel and the cycle it entered
  typedef struct packed {
    logic                  vsync;
    logic                  hsync;
    logic                  de;
    logic [3*`COLOR_W-1:0] vd;
    int                    cycle;
  } expect_t;

  logic                  VCLK_Tx = 1'b0;
  logic                  nVRST_Tx;
  ppu_cfg_word_t         cfg_i;
  pixel_t                pixel_i;
  logic                  vsync_o;
  logic                  hsync_o;
  logic                  de_o;
  logic [3*`COLOR_W-1:0] vd_o;

  expect_t exp_q[$];
  string   test_name;
  int      cycle_cnt;
  int      last_change;

  always #(CLK_PERIOD / 2) VCLK_Tx = ~VCLK_Tx;

  ppu_out_top UUT (
    .VCLK_Tx  (VCLK_Tx),
    .nVRST_Tx (nVRST_Tx),
    .cfg_i    (cfg_i),
    .pixel_i  (pixel_i),
    .vsync_o  (vsync_o),
    .hsync_o  (hsync_o),
    .de_o     (de_o),
    .vd_o     (vd_o)
  );

  // ============================================================
  // Reference model
  // ============================================================

  function automatic logic [7:0] expand_strength(input logic [3:0] code);
    return 8'(16 * (int'(code) + 1) - 1);
  endfunction

  // Band covers the top quarters of the source pixel
  function automatic bit in_band(input logic en, input sl_thickness_e th,
                                 input logic [7:0] pos);
    int quarter;
    quarter = int'(pos) / 64;
    return en && (quarter >= 3 - int'(th));
  endfunction

  function automatic logic [7:0] darken_channel(input logic [7:0] c, input logic [7:0] s);
    int prod;
    prod = int'(c) * int'(s);
    return 8'(int'(c) - prod / 256);
  endfunction

  function automatic logic [7:0] limit_channel(input logic [7:0] c);
    int scaled;
    scaled = int'(c) * int'(`LIMIT_COEFF) / 128;
    return 8'((scaled + 1) / 2 + int'(`LIMIT_OFFSET));
  endfunction

  function automatic expect_t model_pixel(input pixel_t p, input ppu_cfg_word_t cfg,
                                          input int cycle);
    logic            v_en;
    sl_thickness_e   v_th;
    logic [3:0]      v_code;
    logic [2:0][7:0] chan;
    expect_t         e;
    v_en   = cfg.h2v_linked ? cfg.hsl_en : cfg.vsl_en;
    v_th   = cfg.h2v_linked ? cfg.hsl_thickness : cfg.vsl_thickness;
    v_code = cfg.h2v_linked ? cfg.hsl_str_code : cfg.vsl_str_code;
    chan   = {p.red, p.green, p.blue};
    // Vertical scanlines follow the column position
    if (p.de && in_band(v_en, v_th, p.hpos_rel)) begin
      for (int i = 0; i < 3; i++) chan[i] = darken_channel(chan[i], expand_strength(v_code));
    end
    if (p.de && in_band(cfg.hsl_en, cfg.hsl_thickness, p.vpos_rel)) begin
      for (int i = 0; i < 3; i++) begin
        chan[i] = darken_channel(chan[i], expand_strength(cfg.hsl_str_code));
      end
    end
    if (cfg.limited_rgb) begin
      for (int i = 0; i < 3; i++) chan[i] = limit_channel(chan[i]);
    end
    e.vsync = p.vsync;
    e.hsync = p.hsync;
    e.de    = p.de;
    e.vd    = chan;
    e.cycle = cycle;
    return e;
  endfunction

  // ============================================================
  // Stimulus helpers
  // ============================================================

  // Extremes show up often enough to hit both ends of the range
  function automatic logic [7:0] random_channel();
    int unsigned pick;
    pick = $urandom % 8;
    if (pick == 0) return 8'd0;
    else if (pick == 1) return 8'd255;
    else return 8'($urandom);
  endfunction

  function automatic pixel_t random_pixel();
    pixel_t p;
    p.vsync    = 1'($urandom);
    p.hsync    = 1'($urandom);
    p.de       = ($urandom % 4) != 0;
    p.red      = random_channel();
    p.green    = random_channel();
    p.blue     = random_channel();
    p.vpos_rel = 8'($urandom);
    p.hpos_rel = 8'($urandom);
    return p;
  endfunction

  function automatic ppu_cfg_word_t random_cfg(input logic limited, input logic linked,
                                               input logic sl_on);
    ppu_cfg_word_t c;
    c.limited_rgb   = limited;
    c.h2v_linked    = linked;
    c.hsl_en        = sl_on && (($urandom % 4) != 0);
    c.hsl_thickness = sl_thickness_e'(2'($urandom));
    c.hsl_str_code  = 4'($urandom);
    c.vsl_en        = sl_on && (($urandom % 4) != 0);
    c.vsl_thickness = sl_thickness_e'(2'($urandom));
    c.vsl_str_code  = 4'($urandom);
    return c;
  endfunction

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected) begin
      $display("Error: %s expected 0x%0h actual 0x%0h", name, expected, actual);
      $display("Simulation FAILED");
      $fatal(1, "Stopped at the first mismatch");
    end
  endtask

  task automatic check_output(input expect_t e);
    check_value({test_name, " vsync"}, 32'(e.vsync), 32'(vsync_o));
    check_value({test_name, " hsync"}, 32'(e.hsync), 32'(hsync_o));
    check_value({test_name, " de"}, 32'(e.de), 32'(de_o));
    // Colour is undefined if the settings changed while the pixel was in flight
    if (!(last_change >= e.cycle && last_change < e.cycle + LATENCY)) begin
      check_value({test_name, " vd"}, 32'(e.vd), 32'(vd_o));
    end
  endtask

  // One pixel per falling edge, output of the pixel 7 cycles back checked first
  task automatic run_cycle(input pixel_t p, input ppu_cfg_word_t cfg);
    expect_t e;
    @(negedge VCLK_Tx);
    if (exp_q.size() == LATENCY) begin
      e = exp_q.pop_front();
      check_output(e);
    end
    if (cfg != cfg_i) last_change = cycle_cnt;
    cfg_i   = cfg;
    pixel_i = p;
    exp_q.push_back(model_pixel(p, cfg, cycle_cnt));
    cycle_cnt++;
  endtask

  task automatic flush_pipeline(input ppu_cfg_word_t cfg);
    repeat (LATENCY) run_cycle('0, cfg);
  endtask

  // ============================================================
  // Tests
  // ============================================================

  task automatic check_idle_outputs();
    test_name = "reset";
    repeat (IDLE_CYCLES) begin
      @(negedge VCLK_Tx);
      check_value("reset vsync", 32'd0, 32'(vsync_o));
      check_value("reset hsync", 32'd0, 32'(hsync_o));
      check_value("reset de", 32'd0, 32'(de_o));
      check_value("reset vd", 32'd0, 32'(vd_o));
    end
  endtask

  task automatic run_pass_through();
    ppu_cfg_word_t cfg;
    test_name = "pass_through";
    cfg = '0;
    repeat (PASS_PIXELS) run_cycle(random_pixel(), cfg);
    flush_pipeline(cfg);
  endtask

  task automatic run_scanlines(input logic linked);
    ppu_cfg_word_t cfg;
    test_name = linked ? "linked_scanlines" : "scanlines";
    cfg = '0;
    repeat (SL_BLOCKS) begin
      cfg = random_cfg(1'b0, linked, 1'b1);
      repeat (SL_BLOCK_LEN) run_cycle(random_pixel(), cfg);
    end
    flush_pipeline(cfg);
  endtask

  task automatic run_limited_range();
    ppu_cfg_word_t cfg;
    pixel_t        p;
    test_name = "limited_range";
    cfg = random_cfg(1'b1, 1'b0, 1'b0);
    run_cycle('0, cfg);
    p = random_pixel();
    p.de    = 1'b1;
    p.red   = 8'd0;
    p.green = 8'd0;
    p.blue  = 8'd0;
    run_cycle(p, cfg);
    p.red   = 8'd255;
    p.green = 8'd255;
    p.blue  = 8'd255;
    run_cycle(p, cfg);
    repeat (LIMIT_PIXELS) run_cycle(random_pixel(), cfg);
    flush_pipeline(cfg);
  endtask

  task automatic run_config_change();
    ppu_cfg_word_t cfg;
    int            hold;
    test_name = "config_change";
    cfg  = '0;
    hold = 0;
    for (int i = 0; i < CHANGE_PIXELS; i++) begin
      if (hold == 0) begin
        cfg  = random_cfg(1'($urandom), 1'($urandom), 1'b1);
        hold = 10 + int'($urandom % 20);
      end
      hold--;
      run_cycle(random_pixel(), cfg);
    end
    flush_pipeline(cfg);
  endtask

  // ============================================================
  // Main sequence and watchdog
  // ============================================================

  initial begin
    void'($urandom(32'h1bbe_8c1e));
    nVRST_Tx    = 1'b0;
    cfg_i       = '0;
    pixel_i     = '0;
    cycle_cnt   = 0;
    last_change = -1000;
    test_name   = "reset";
    repeat (RESET_CYCLES) @(negedge VCLK_Tx);
    nVRST_Tx = 1'b1;
    check_idle_outputs();
    run_pass_through();
    run_scanlines(1'b0);
    run_scanlines(1'b1);
    run_limited_range();
    run_config_change();
    if (UUT.props_u.assert_fail_cnt != 0) begin
      $display("Bound assertions failed %0d times", UUT.props_u.assert_fail_cnt);
      $display("Simulation FAILED");
      $fatal(1, "Assertion failures during the run");
    end else begin
      $display("Simulation PASSED");
      $finish;
    end
  end

  initial begin
    #(TIMEOUT_NS);
    $display("Watchdog expired after %0d ns before the tests completed", TIMEOUT_NS);
    $display("Simulation FAILED");
    $fatal(1, "Timeout");
  end

endmodule

/* tb.f */
+incdir+.
ppu_pkg.sv
ppu_cfg_regs.sv
scanline_emu.sv
rgb_range_limit.sv
ppu_out_top.sv
ppu_out_properties.sv
tb_ppu_out.sv

/* run.sh */
#!/bin/sh
# Build and run the output post-processing testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
  -f tb.f \
  --top-module tb_ppu_out \
  -o tb_ppu_out
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit $status
fi

./obj_dir/tb_ppu_out
status=$?
if [ $status -ne 0 ]; then
  echo "Simulation run ended with status $status"
  exit $status
fi

exit 0
